// File: Makefile
# Verilator build and run of the divide cluster testbench

VERILATOR ?= verilator
TOP       ?= div_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := all tests passed

SOURCES := $(wildcard source/*.sv) $(wildcard dv/*.sv) $(wildcard dv/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/div_model.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// expected RV64 M divide result; needs div_pkg compiled first
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef DIV_MODEL_SVH
`define DIV_MODEL_SVH

function automatic logic [div_pkg::XLEN-1:0] div_ref(
    input logic [div_pkg::OP_W-1:0] op,
    input logic [div_pkg::XLEN-1:0] dividend,
    input logic [div_pkg::XLEN-1:0] divisor
);
    logic                      is_uns;
    logic                      want_rem;
    logic                      is_word;
    logic [div_pkg::XLEN-1:0]  a;
    logic [div_pkg::XLEN-1:0]  b;
    logic [div_pkg::XLEN-1:0]  q;
    logic [div_pkg::XLEN-1:0]  r;
    logic [div_pkg::XLEN-1:0]  res;
    is_uns   = (op == div_pkg::OP_DIVU) || (op == div_pkg::OP_REMU) ||
               (op == div_pkg::OP_DIVUW) || (op == div_pkg::OP_REMUW);
    want_rem = (op == div_pkg::OP_REM) || (op == div_pkg::OP_REMU) ||
               (op == div_pkg::OP_REMW) || (op == div_pkg::OP_REMUW);
    is_word  = (op == div_pkg::OP_DIVW) || (op == div_pkg::OP_DIVUW) ||
               (op == div_pkg::OP_REMW) || (op == div_pkg::OP_REMUW);
    a = dividend;
    b = divisor;
    if (is_word) begin
        a = is_uns ? {32'h0, dividend[31:0]} : {{32{dividend[31]}}, dividend[31:0]};
        b = is_uns ? {32'h0, divisor[31:0]} : {{32{divisor[31]}}, divisor[31:0]};
    end
    if (b == '0) begin
        q = '1;
        r = a;
    end else if (!is_uns && (a == 64'h8000_0000_0000_0000) && (b == '1)) begin
        q = a;
        r = '0;
    end else if (is_uns) begin
        q = a / b;
        r = a % b;
    end else begin
        q = $signed(a) / $signed(b);
        r = $signed(a) % $signed(b);
    end
    res = want_rem ? r : q;
    if (is_word) begin
        res = {{32{res[31]}}, res[31:0]};
    end
    return res;
endfunction

`endif

// File: dv/div_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// results are paired by tag; keeps at most NUM_LANES requests in flight
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module div_tb;
    import div_pkg::*;

    `include "div_model.svh"

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    localparam int SEED         = 41070;
    localparam int N_TAGS       = 1 << TAG_W;
    // 96 random, 24 divide by zero, 16 overflow, 64 word form, 24 burst
    localparam int N_REQ        = 224;
    localparam int WATCHDOG_CYCLES =
        N_REQ * (LANE_CYCLES + NUM_LANES + 10) + RESET_CYCLES;

    logic              clk;
    logic              rst_n;
    logic              req;
    logic [OP_W-1:0]   op;
    logic [TAG_W-1:0]  tag;
    logic [XLEN-1:0]   dividend;
    logic [XLEN-1:0]   divisor;
    logic              busy;
    logic              done;
    logic [TAG_W-1:0]  done_tag;
    logic [XLEN-1:0]   result;

    // scoreboard indexed by tag
    logic [XLEN-1:0]   expected [N_TAGS];
    logic              outstanding [N_TAGS];
    int                in_flight;
    int                completed;
    int                mismatches;
    int                other_errors;
    logic              saw_busy;

    div_cluster UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .op       (op),
        .tag      (tag),
        .dividend (dividend),
        .divisor  (divisor),
        .busy     (busy),
        .done     (done),
        .done_tag (done_tag),
        .result   (result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic int free_tag();
        for (int t = 0; t < N_TAGS; t++) begin
            if (!outstanding[t]) begin
                return t;
            end
        end
        return -1;
    endfunction

    // mix of full width, shifted, negated and tiny values
    function automatic logic [XLEN-1:0] rand_operand();
        logic [XLEN-1:0] v;
        v = {$urandom(), $urandom()};
        case ($urandom_range(3, 0))
            0: v = v;
            1: v = v >> $urandom_range(63, 0);
            2: v = -(v >> $urandom_range(63, 0));
            default: v = XLEN'($urandom_range(15, 0));
        endcase
        return v;
    endfunction

    // holds req high across back-to-back calls, drops it while waiting
    task automatic issue(input logic [OP_W-1:0] req_op, input logic [XLEN-1:0] req_a,
                         input logic [XLEN-1:0] req_b, input logic [XLEN-1:0] req_exp);
        int t;
        @(negedge clk);
        t = free_tag();
        while (busy || in_flight >= NUM_LANES || t < 0) begin
            @(posedge clk);
            req <= 1'b0;
            @(negedge clk);
            t = free_tag();
        end
        @(posedge clk);
        req      <= 1'b1;
        op       <= req_op;
        tag      <= TAG_W'(t);
        dividend <= req_a;
        divisor  <= req_b;
        expected[t]    = req_exp;
        outstanding[t] = 1'b1;
        in_flight++;
    endtask

    task automatic wait_all_done();
        @(posedge clk);
        req <= 1'b0;
        while (in_flight != 0) begin
            @(negedge clk);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequences
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic run_random_ops();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        for (int o = 0; o < 8; o++) begin
            for (int k = 0; k < 12; k++) begin
                a = rand_operand();
                b = rand_operand();
                issue(OP_W'(o), a, b, div_ref(OP_W'(o), a, b));
            end
        end
    endtask

    task automatic run_div_by_zero();
        logic [OP_W-1:0] o;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] exp;
        for (int i = 0; i < 8; i++) begin
            for (int k = 0; k < 3; k++) begin
                o = OP_W'(i);
                a = (k == 0) ? '0 : rand_operand();
                if (k == 2) begin
                    a[XLEN-1] = 1'b1;
                    a[31]     = 1'b1;
                end
                // word forms see only the low half of the divisor
                b = o[2] ? {$urandom(), 32'h0} : '0;
                if (!o[1]) begin
                    exp = '1;
                end else begin
                    exp = o[2] ? {{32{a[31]}}, a[31:0]} : a;
                end
                issue(o, a, b, exp);
            end
        end
    endtask

    task automatic run_overflow();
        logic [XLEN-1:0] min64;
        logic [XLEN-1:0] min32;
        logic [XLEN-1:0] neg1;
        logic [XLEN-1:0] neg1_w;
        min64 = {1'b1, {(XLEN-1){1'b0}}};
        neg1  = '1;
        for (int rep = 0; rep < 2; rep++) begin
            min32  = {$urandom(), 32'h8000_0000};
            neg1_w = {$urandom(), 32'hffff_ffff};
            issue(OP_DIV, min64, neg1, min64);
            issue(OP_REM, min64, neg1, '0);
            issue(OP_DIVW, min32, neg1_w, 64'hffff_ffff_8000_0000);
            issue(OP_REMW, min32, neg1_w, '0);
            // same operands unsigned where no special case applies
            issue(OP_DIVU, min64, neg1, div_ref(OP_DIVU, min64, neg1));
            issue(OP_REMU, min64, neg1, div_ref(OP_REMU, min64, neg1));
            issue(OP_DIVUW, min32, neg1_w, div_ref(OP_DIVUW, min32, neg1_w));
            issue(OP_REMUW, min32, neg1_w, div_ref(OP_REMUW, min32, neg1_w));
        end
    endtask

    // clean and dirty upper halves must give one result
    task automatic run_word_upper_bits();
        logic [OP_W-1:0] o;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] exp;
        for (int i = 4; i < 8; i++) begin
            for (int k = 0; k < 8; k++) begin
                o   = OP_W'(i);
                a   = rand_operand() >> 32;
                b   = rand_operand() >> 32;
                a   = {32'h0, a[31:0] ^ $urandom()};
                exp = div_ref(o, a, b);
                issue(o, a, b, exp);
                issue(o, {$urandom(), a[31:0]}, {$urandom(), b[31:0]}, exp);
            end
        end
    endtask

    task automatic run_burst();
        logic [OP_W-1:0] o;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        wait_all_done();
        saw_busy = 1'b0;
        for (int k = 0; k < 24; k++) begin
            o = OP_W'($urandom_range(7, 0));
            a = rand_operand();
            b = rand_operand();
            issue(o, a, b, div_ref(o, a, b));
        end
        wait_all_done();
        assert (saw_busy) else begin
            $display("busy never rose during the back-to-back burst");
            other_errors++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare and monitors
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        if (rst_n && busy) begin
            saw_busy = 1'b1;
        end
        if (rst_n && done) begin
            completed++;
            assert (outstanding[done_tag]) else begin
                $display("result arrived for tag %0d with no request outstanding", done_tag);
                other_errors++;
            end
            if (outstanding[done_tag]) begin
                assert (result === expected[done_tag]) else begin
                    $display("Mismatch result: tag %h got %h expected %h",
                             done_tag, result, expected[done_tag]);
                    mismatches++;
                end
                outstanding[done_tag] = 1'b0;
                in_flight--;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired with %0d requests still in flight", in_flight);
        $display("tests failed");
        $finish;
    end

    initial begin
        rst_n        = 1'b0;
        req          = 1'b0;
        op           = '0;
        tag          = '0;
        dividend     = '0;
        divisor      = '0;
        in_flight    = 0;
        completed    = 0;
        mismatches   = 0;
        other_errors = 0;
        saw_busy     = 1'b0;
        for (int t = 0; t < N_TAGS; t++) begin
            outstanding[t] = 1'b0;
            expected[t]    = '0;
        end
        void'($urandom(SEED));
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        run_random_ops();
        run_div_by_zero();
        run_overflow();
        run_word_upper_bits();
        run_burst();
        wait_all_done();

        // a stray or repeated result would still show up in this window
        repeat (LANE_CYCLES + NUM_LANES) @(posedge clk);

        assert (completed == N_REQ) else begin
            $display("expected %0d results but %0d arrived", N_REQ, completed);
            other_errors++;
        end

        $display("checked %0d results: %0d mismatches, %0d other errors",
                 completed, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/div_cluster.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// hold req low while busy; pair each done with its request by tag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module div_cluster (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        req,
    input  logic [div_pkg::OP_W-1:0]    op,
    input  logic [div_pkg::TAG_W-1:0]   tag,
    input  logic [div_pkg::XLEN-1:0]    dividend,
    input  logic [div_pkg::XLEN-1:0]    divisor,
    output logic                        busy,
    output logic                        done,
    output logic [div_pkg::TAG_W-1:0]   done_tag,
    output logic [div_pkg::XLEN-1:0]    result
);
    import div_pkg::*;

    logic [NUM_LANES-1:0] occupied;
    logic [NUM_LANES-1:0] start;
    logic [NUM_LANES-1:0] result_valid;
    logic [NUM_LANES-1:0] drain;
    logic [XLEN-1:0]      lane_result [NUM_LANES];
    logic [TAG_W-1:0]     lane_tag [NUM_LANES];

    div_dispatch u_dispatch (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .occupied (occupied),
        .start    (start),
        .busy     (busy)
    );

    // operands are broadcast, only the started lane samples them
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        div_lane u_lane (
            .clk          (clk),
            .rst_n        (rst_n),
            .start        (start[i]),
            .drain        (drain[i]),
            .op           (op),
            .tag          (tag),
            .dividend     (dividend),
            .divisor      (divisor),
            .occupied     (occupied[i]),
            .result_valid (result_valid[i]),
            .result       (lane_result[i]),
            .result_tag   (lane_tag[i])
        );
    end

    div_collect u_collect (
        .clk          (clk),
        .rst_n        (rst_n),
        .result_valid (result_valid),
        .lane_result  (lane_result),
        .lane_tag     (lane_tag),
        .drain        (drain),
        .done         (done),
        .done_tag     (done_tag),
        .result       (result)
    );

endmodule

`default_nettype wire

// File: source/div_collect.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one result per cycle, no output stall; results may leave out of order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module div_collect (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [div_pkg::NUM_LANES-1:0] result_valid,
    input  logic [div_pkg::XLEN-1:0]      lane_result [div_pkg::NUM_LANES],
    input  logic [div_pkg::TAG_W-1:0]     lane_tag [div_pkg::NUM_LANES],
    output logic [div_pkg::NUM_LANES-1:0] drain,
    output logic                          done,
    output logic [div_pkg::TAG_W-1:0]     done_tag,
    output logic [div_pkg::XLEN-1:0]      result
);
    import div_pkg::*;

    logic [LANE_IDX_W-1:0] ptr_q;
    logic [LANE_IDX_W-1:0] pick;
    logic                  any_valid;

    // first finished lane at or after the pointer
    always_comb begin
        int idx;
        any_valid = 1'b0;
        pick      = ptr_q;
        for (int k = 0; k < NUM_LANES; k++) begin
            idx = int'(ptr_q) + k;
            if (idx >= NUM_LANES) begin
                idx = idx - NUM_LANES;
            end
            if (!any_valid && result_valid[idx]) begin
                any_valid = 1'b1;
                pick      = LANE_IDX_W'(idx);
            end
        end
        drain = '0;
        if (any_valid) begin
            drain[pick] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr_q <= '0;
            done  <= 1'b0;
        end else begin
            done <= any_valid;
            if (any_valid) begin
                if (pick == LANE_IDX_W'(NUM_LANES - 1)) begin
                    ptr_q <= '0;
                end else begin
                    ptr_q <= pick + 1'b1;
                end
            end
        end
    end

    // output payload is meaningful only with done
    always_ff @(posedge clk) begin
        if (any_valid) begin
            done_tag <= lane_tag[pick];
            result   <= lane_result[pick];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_drain_legal: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(drain) && ((drain & ~result_valid) == '0));

endmodule

`default_nettype wire

// File: source/div_dispatch.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// req while busy is not accepted; the requester must hold off
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module div_dispatch (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           req,
    input  logic [div_pkg::NUM_LANES-1:0]  occupied,
    output logic [div_pkg::NUM_LANES-1:0]  start,
    output logic                           busy
);
    import div_pkg::*;

    logic [LANE_IDX_W-1:0] ptr_q;
    logic [LANE_IDX_W-1:0] pick;

    assign busy = &occupied;

    // first free lane at or after the pointer
    always_comb begin
        int   idx;
        logic found;
        found = 1'b0;
        pick  = ptr_q;
        for (int k = 0; k < NUM_LANES; k++) begin
            idx = int'(ptr_q) + k;
            if (idx >= NUM_LANES) begin
                idx = idx - NUM_LANES;
            end
            if (!found && !occupied[idx]) begin
                found = 1'b1;
                pick  = LANE_IDX_W'(idx);
            end
        end
        start = '0;
        if (req && found) begin
            start[pick] = 1'b1;
        end
    end

    // pointer moves just past the lane started
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr_q <= '0;
        end else if (|start) begin
            if (pick == LANE_IDX_W'(NUM_LANES - 1)) begin
                ptr_q <= '0;
            end else begin
                ptr_q <= pick + 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_start_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(start));

    // requester must see busy before issuing
    a_no_req_busy: assert property (@(posedge clk) disable iff (!rst_n)
        !(req && busy));

endmodule

`default_nettype wire

// File: source/div_lane.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fixed latency of LANE_CYCLES, no early exit; result held until drain
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module div_lane (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic                        drain,
    input  logic [div_pkg::OP_W-1:0]    op,
    input  logic [div_pkg::TAG_W-1:0]   tag,
    input  logic [div_pkg::XLEN-1:0]    dividend,
    input  logic [div_pkg::XLEN-1:0]    divisor,
    output logic                        occupied,
    output logic                        result_valid,
    output logic [div_pkg::XLEN-1:0]    result,
    output logic [div_pkg::TAG_W-1:0]   result_tag
);
    import div_pkg::*;

    logic                         prep_q;
    logic                         run_q;
    logic                         fix_q;
    logic [$clog2(DIV_STEPS)-1:0] step_q;
    logic                         last_step;

    logic [OP_W-1:0] op_q;
    logic [XLEN-1:0] quo_q;
    logic [XLEN-1:0] rem_q;
    logic [XLEN-1:0] dsr_q;
    logic            q_neg_q;
    logic            r_neg_q;
    logic            dz_q;
    logic            ovf_q;

    logic            is_uns;
    logic            want_rem;
    logic            is_word;
    logic [XLEN-1:0] a_ext;
    logic [XLEN-1:0] b_ext;
    logic [XLEN-1:0] a_min;
    logic            a_neg;
    logic            b_neg;
    logic [XLEN:0]   rem_shift;
    logic [XLEN+1:0] trial;
    logic [XLEN-1:0] quo_fix;
    logic [XLEN-1:0] rem_fix;
    logic [XLEN-1:0] pick;

    assign is_uns   = op_q[0];
    assign want_rem = op_q[1];
    assign is_word  = op_q[2];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // preparation from the raw operands held in quo_q and dsr_q
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        a_ext = quo_q;
        b_ext = dsr_q;
        a_min = {1'b1, {(XLEN-1){1'b0}}};
        if (is_word) begin
            a_ext = {{(XLEN-32){quo_q[31] & !is_uns}}, quo_q[31:0]};
            b_ext = {{(XLEN-32){dsr_q[31] & !is_uns}}, dsr_q[31:0]};
            a_min = {{(XLEN-31){1'b1}}, {31{1'b0}}};
        end
        a_neg = !is_uns && a_ext[XLEN-1];
        b_neg = !is_uns && b_ext[XLEN-1];
    end

    // one restoring step
    assign rem_shift = {rem_q, quo_q[XLEN-1]};
    assign trial     = {1'b0, rem_shift} - {2'b00, dsr_q};
    assign last_step = run_q && (step_q == $bits(step_q)'(DIV_STEPS - 1));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fixup
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        quo_fix = q_neg_q ? -quo_q : quo_q;
        // on divide by zero the remainder path already yields the dividend
        rem_fix = r_neg_q ? -rem_q : rem_q;
        if (dz_q) begin
            quo_fix = '1;
        end
        if (ovf_q) begin
            quo_fix = is_word ? {{(XLEN-31){1'b1}}, {31{1'b0}}}
                              : {1'b1, {(XLEN-1){1'b0}}};
            rem_fix = '0;
        end
        pick = want_rem ? rem_fix : quo_fix;
        if (is_word) begin
            pick = {{(XLEN-32){pick[31]}}, pick[31:0]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occupied     <= 1'b0;
            prep_q       <= 1'b0;
            run_q        <= 1'b0;
            fix_q        <= 1'b0;
            step_q       <= '0;
            result_valid <= 1'b0;
        end else begin
            prep_q <= start;
            fix_q  <= last_step;
            if (start) begin
                occupied <= 1'b1;
            end else if (drain) begin
                occupied <= 1'b0;
            end
            if (prep_q) begin
                run_q  <= 1'b1;
                step_q <= '0;
            end else if (run_q) begin
                step_q <= step_q + 1'b1;
                if (last_step) begin
                    run_q <= 1'b0;
                end
            end
            if (fix_q) begin
                result_valid <= 1'b1;
            end else if (drain) begin
                result_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            op_q       <= op;
            result_tag <= tag;
            quo_q      <= dividend;
            dsr_q      <= divisor;
        end else if (prep_q) begin
            quo_q   <= a_neg ? -a_ext : a_ext;
            dsr_q   <= b_neg ? -b_ext : b_ext;
            rem_q   <= '0;
            q_neg_q <= a_neg ^ b_neg;
            r_neg_q <= a_neg;
            dz_q    <= (b_ext == '0);
            ovf_q   <= !is_uns && (b_ext == '1) && (a_ext == a_min);
        end else if (run_q) begin
            if (!trial[XLEN+1]) begin
                rem_q <= trial[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b1};
            end else begin
                rem_q <= rem_shift[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b0};
            end
        end
        if (fix_q) begin
            result <= pick;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_start_free: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> !occupied);

    a_drain_valid: assert property (@(posedge clk) disable iff (!rst_n)
        drain |-> result_valid);

    // result_valid is set on the LANE_CYCLES-th edge after the start edge
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> ##(LANE_CYCLES + 1) $rose(result_valid));

endmodule

`default_nettype wire

// File: source/div_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// NUM_LANES may range 1..8; TAG_W must cover NUM_LANES tags in flight
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package div_pkg;

    localparam int XLEN      = 64;
    localparam int NUM_LANES = 4;
    localparam int TAG_W     = 4;

    // lane index width is at least 1 for a single lane
    localparam int LANE_IDX_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // opcodes
    // bit 0 unsigned, bit 1 remainder, bit 2 word form
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int OP_W = 3;

    localparam logic [OP_W-1:0] OP_DIV   = 3'd0;
    localparam logic [OP_W-1:0] OP_DIVU  = 3'd1;
    localparam logic [OP_W-1:0] OP_REM   = 3'd2;
    localparam logic [OP_W-1:0] OP_REMU  = 3'd3;
    localparam logic [OP_W-1:0] OP_DIVW  = 3'd4;
    localparam logic [OP_W-1:0] OP_DIVUW = 3'd5;
    localparam logic [OP_W-1:0] OP_REMW  = 3'd6;
    localparam logic [OP_W-1:0] OP_REMUW = 3'd7;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lane timing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int DIV_STEPS = 64;

    // prep + steps + fixup
    localparam int LANE_CYCLES = DIV_STEPS + 2;

endpackage

`default_nettype wire

// File: sources.f
+incdir+dv
source/div_pkg.sv
source/div_dispatch.sv
source/div_lane.sv
source/div_collect.sv
source/div_cluster.sv
dv/div_tb.sv
